// File: Bender.yml
package:
  name: lsu_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/lsu_pkg.sv
      - source/lsu_mem_if.sv
      - source/lsu.sv
      - source/data_ram.sv
      - source/lsu_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/lsu_assert.sv
      - testbench/lsu_tb.sv

// File: build.f
+incdir+include
source/lsu_pkg.sv
source/lsu_mem_if.sv
source/lsu.sv
source/data_ram.sv
source/lsu_subsystem.sv
testbench/lsu_assert.sv
testbench/lsu_tb.sv

// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data path and byte address width of the core
`define XLEN 32

// One write strobe per byte of a data word
`define STRB_W 4

// Default data RAM size in words, a power of two
`define RAM_DEPTH_WORDS 256

`endif

// File: source/data_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_defines.svh"

module data_ram import lsu_pkg::*; #(
  parameter int depth_words = `RAM_DEPTH_WORDS
) (
  input  logic    clock,
  input  logic    reset,
  lsu_mem_if.slave mem
);

  localparam int idx_w = $clog2(depth_words);

  logic [`XLEN-1:0] ram_q [depth_words];

  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;
  logic             wr_fits;
  logic             rd_fits;

  // True when the access stays inside one word
  function automatic logic fits_word(input logic [1:0] lane, input access_size_e size);
    logic [2:0] span;
    case (size)
      size_byte: span = 3'd1;
      size_half: span = 3'd2;
      size_word: span = 3'd4;
      default:   span = 3'd7;
    endcase
    return ({2'b00, lane} + {1'b0, span}) <= 4'd4;
  endfunction

  // Upper address bits wrap around the array
  assign wr_idx  = mem.awaddr[idx_w+1:2];
  assign rd_idx  = mem.araddr[idx_w+1:2];
  assign wr_fits = fits_word(mem.awaddr[1:0], mem.awsize);
  assign rd_fits = fits_word(mem.araddr[1:0], mem.arsize);

  always_ff @(posedge clock) begin
    if (mem.wvalid && wr_fits) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (mem.wstrb[b]) begin
          ram_q[wr_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
    if (mem.arvalid) begin
      mem.rdata <= rd_fits ? ram_q[rd_idx] : '0; // Out of range reads return zero
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem.rvalid <= 1'b0;
    end else begin
      mem.rvalid <= mem.arvalid;
    end
  end

endmodule

`default_nettype wire

// File: source/lsu.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_defines.svh"

module lsu import lsu_pkg::*; (
  input  logic              clock_i,
  input  logic              reset_i,

  input  logic              req_i,
  input  lsu_op_e           lsu_op_i,
  input  logic [`XLEN-1:0]  rdata1_i,
  input  logic [`XLEN-1:0]  imm_i,
  input  logic [`XLEN-1:0]  rdata2_i,

  lsu_mem_if.master         mem,

  output logic [`XLEN-1:0]  mem_result_o,
  output logic              result_valid_o,
  output logic              misaligned_o
);

  logic [`XLEN-1:0]   address;
  logic [1:0]         lane;
  logic               is_load;
  logic               is_store;
  access_size_e       size;
  logic               misaligned;

  logic [`XLEN-1:0]   store_data;
  logic [`STRB_W-1:0] base_strb;

  lsu_op_e            pend_op;
  logic [1:0]         pend_lane;
  logic [`XLEN-1:0]   lane_data;
  logic [`XLEN-1:0]   load_value;

  assign address = rdata1_i + imm_i;
  assign lane    = address[1:0];

  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    size     = size_byte;
    case (lsu_op_i)
      op_lb, op_lbu: begin
        is_load = 1'b1;
        size    = size_byte;
      end
      op_lh, op_lhu: begin
        is_load = 1'b1;
        size    = size_half;
      end
      op_lw: begin
        is_load = 1'b1;
        size    = size_word;
      end
      op_sb: begin
        is_store = 1'b1;
        size     = size_byte;
      end
      op_sh: begin
        is_store = 1'b1;
        size     = size_half;
      end
      op_sw: begin
        is_store = 1'b1;
        size     = size_word;
      end
      default: ;
    endcase
  end

  // Halfwords need an even lane, words need lane zero
  always_comb begin
    case (size)
      size_half: misaligned = lane[0];
      size_word: misaligned = (lane != 2'd0);
      default:   misaligned = 1'b0;
    endcase
  end

  assign misaligned_o = req_i && (is_load || is_store) && misaligned;

  // Store payload is trimmed to its size, then moved up to the addressed lane
  always_comb begin
    case (size)
      size_half: begin
        store_data = {{(`XLEN-16){1'b0}}, rdata2_i[15:0]};
        base_strb  = `STRB_W'(3);
      end
      size_word: begin
        store_data = rdata2_i;
        base_strb  = '1;
      end
      default: begin
        store_data = {{(`XLEN-8){1'b0}}, rdata2_i[7:0]};
        base_strb  = `STRB_W'(1);
      end
    endcase
  end

  assign mem.awaddr  = address;
  assign mem.awsize  = size;
  assign mem.wdata   = store_data << {lane, 3'b000};
  assign mem.wstrb   = base_strb << lane;
  assign mem.wvalid  = req_i && is_store && !misaligned;

  assign mem.araddr  = address;
  assign mem.arsize  = size;
  assign mem.arvalid = req_i && is_load && !misaligned;

  // One entry is enough since the RAM answers in the very next cycle
  always_ff @(posedge clock_i) begin
    if (mem.arvalid) begin
      pend_op   <= lsu_op_i;
      pend_lane <= lane;
    end
  end

  assign lane_data = mem.rdata >> {pend_lane, 3'b000};

  always_comb begin
    case (pend_op)
      op_lb:   load_value = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
      op_lbu:  load_value = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
      op_lh:   load_value = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
      op_lhu:  load_value = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
      op_lw:   load_value = mem.rdata;
      default: load_value = '0;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      mem_result_o   <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= mem.rvalid;
      if (mem.rvalid) begin
        mem_result_o <= load_value; // Holds its value between loads
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_mem_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_defines.svh"

interface lsu_mem_if import lsu_pkg::*; ();

  logic [`XLEN-1:0]   awaddr;
  access_size_e       awsize;
  logic [`XLEN-1:0]   wdata;
  logic [`STRB_W-1:0] wstrb;
  logic               wvalid; // One cycle, RAM writes at the closing edge

  logic [`XLEN-1:0]   araddr;
  access_size_e       arsize;
  logic               arvalid;

  logic [`XLEN-1:0]   rdata;
  logic               rvalid; // High for exactly the cycle after arvalid

  modport master (
    output awaddr, awsize, wdata, wstrb, wvalid,
    output araddr, arsize, arvalid,
    input  rdata, rvalid
  );

  modport slave (
    input  awaddr, awsize, wdata, wstrb, wvalid,
    input  araddr, arsize, arvalid,
    output rdata, rvalid
  );

  modport monitor (
    input awaddr, awsize, wdata, wstrb, wvalid,
    input araddr, arsize, arvalid, rdata, rvalid
  );

endinterface

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Operation handed to the load/store unit with each issue strobe
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1, // Signed byte
    op_lh   = 4'd2, // Signed halfword
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } lsu_op_e;

  // Bytes per access as log2, same coding as an AXI size field
  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } access_size_e;

endpackage

`default_nettype wire

// File: source/lsu_subsystem.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_defines.svh"

module lsu_subsystem import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,

  input  logic              req_i,
  input  lsu_op_e           lsu_op_i,
  input  logic [`XLEN-1:0]  rdata1_i,
  input  logic [`XLEN-1:0]  imm_i,
  input  logic [`XLEN-1:0]  rdata2_i,

  output logic [`XLEN-1:0]  mem_result_o,
  output logic              result_valid_o,
  output logic              misaligned_o
);

  lsu_mem_if bus0 ();

  lsu lsu0 (
    .clock_i        (clock),
    .reset_i        (reset),
    .req_i          (req_i),
    .lsu_op_i       (lsu_op_i),
    .rdata1_i       (rdata1_i),
    .imm_i          (imm_i),
    .rdata2_i       (rdata2_i),
    .mem            (bus0.master),
    .mem_result_o   (mem_result_o),
    .result_valid_o (result_valid_o),
    .misaligned_o   (misaligned_o)
  );

  data_ram #(
    .depth_words (`RAM_DEPTH_WORDS)
  ) ram0 (
    .clock (clock),
    .reset (reset),
    .mem   (bus0.slave)
  );

endmodule

`default_nettype wire

// File: testbench/lsu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_assert (
  input logic        clock,
  input logic        reset,
  lsu_mem_if.monitor mem
);

  int failure_count = 0; // Read by the testbench during and after the run

  // The RAM answers every read in the very next cycle
  rvalid_after_arvalid: assert property (
    @(posedge clock) disable iff (reset) mem.arvalid |=> mem.rvalid
  ) else begin
    $error("rvalid missing one cycle after arvalid");
    failure_count++;
  end

  rvalid_only_after_arvalid: assert property (
    @(posedge clock) disable iff (reset) mem.rvalid |-> $past(mem.arvalid)
  ) else begin
    $error("rvalid without arvalid in the cycle before");
    failure_count++;
  end

  no_read_write_overlap: assert property (
    @(posedge clock) disable iff (reset) !(mem.wvalid && mem.arvalid)
  ) else begin
    $error("wvalid and arvalid high in the same cycle");
    failure_count++;
  end

  strobes_quiet_in_reset: assert property (
    @(posedge clock) reset |-> (!mem.wvalid && !mem.arvalid)
  ) else begin
    $error("request strobe asserted during reset");
    failure_count++;
  end

  // First reset edge clears rvalid, so it is checked from the second one on
  rvalid_quiet_in_reset: assert property (
    @(posedge clock) (reset ##1 reset) |-> !mem.rvalid
  ) else begin
    $error("rvalid asserted during reset");
    failure_count++;
  end

endmodule

bind lsu_subsystem lsu_assert assert0 (
  .clock (clock),
  .reset (reset),
  .mem   (bus0.monitor)
);

`default_nettype wire

// File: testbench/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int ram_bytes = `RAM_DEPTH_WORDS * `STRB_W;

  typedef struct {
    lsu_op_e          op;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] offset;
    logic [`XLEN-1:0] store_data;
    logic             exp_misaligned;
    logic [`XLEN-1:0] exp_result; // Only meaningful for aligned loads
  } row_t;

  logic             clock;
  logic             reset;
  logic             req_i;
  lsu_op_e          lsu_op_i;
  logic [`XLEN-1:0] rdata1_i;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] rdata2_i;
  logic [`XLEN-1:0] mem_result_o;
  logic             result_valid_o;
  logic             misaligned_o;

  row_t             rows[$];
  logic [7:0]       ref_mem [ram_bytes]; // Byte image of the data RAM
  logic [`XLEN-1:0] exp_q[$];
  int               issue_q[$];
  logic [`XLEN-1:0] last_result = '0;
  int               cycle = 0;
  logic             table_built = 1'b0;
  lsu_op_e          mixed_ops [8] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};

  lsu_subsystem dut0 (
    .clock          (clock),
    .reset          (reset),
    .req_i          (req_i),
    .lsu_op_i       (lsu_op_i),
    .rdata1_i       (rdata1_i),
    .imm_i          (imm_i),
    .rdata2_i       (rdata2_i),
    .mem_result_o   (mem_result_o),
    .result_valid_o (result_valid_o),
    .misaligned_o   (misaligned_o)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  function automatic int access_bytes(input lsu_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_sw:         return 4;
      default:              return 0;
    endcase
  endfunction

  function automatic logic is_load_op(input lsu_op_e op);
    return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  endfunction

  function automatic logic is_store_op(input lsu_op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // An access is legal only at an address that is a multiple of its size
  function automatic logic expect_misaligned(input lsu_op_e op, input logic [`XLEN-1:0] addr);
    int n;
    n = access_bytes(op);
    if (n == 0) begin
      return 1'b0;
    end
    return (addr % n) != 0;
  endfunction

  task automatic ref_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                           input int n);
    for (int i = 0; i < n; i++) begin
      ref_mem[(addr + i) % ram_bytes] = data[8*i +: 8];
    end
  endtask

  // Little endian gather, then sign fill for the signed loads
  function automatic logic [`XLEN-1:0] ref_load(input lsu_op_e op, input logic [`XLEN-1:0] addr);
    logic [`XLEN-1:0] value;
    int               n;
    value = '0;
    n = access_bytes(op);
    for (int i = 0; i < n; i++) begin
      value[8*i +: 8] = ref_mem[(addr + i) % ram_bytes];
    end
    if ((op == op_lb || op == op_lh) && value[8*n-1]) begin
      for (int b = 8 * n; b < `XLEN; b++) begin
        value[b] = 1'b1;
      end
    end
    return value;
  endfunction

  task automatic add_access(input lsu_op_e op, input logic [`XLEN-1:0] base,
                            input logic [`XLEN-1:0] offset, input logic [`XLEN-1:0] data);
    row_t             row;
    logic [`XLEN-1:0] addr;
    addr = base + offset;
    row.op = op;
    row.base = base;
    row.offset = offset;
    row.store_data = data;
    row.exp_misaligned = expect_misaligned(op, addr);
    row.exp_result = '0;
    if (!row.exp_misaligned) begin
      if (is_store_op(op)) begin
        ref_store(addr, data, access_bytes(op));
      end
      if (is_load_op(op)) begin
        row.exp_result = ref_load(op, addr);
      end
    end
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] off;
    logic [`XLEN-1:0] base;
    // Every word the loads below can reach gets a known value first
    for (int w = 0; w < 16; w++) add_access(op_sw, 32'h0, 4 * w, $urandom());
    for (int w = 0; w < 16; w++) add_access(op_lw, 32'h20, 4 * w - 32'h20, '0);
    add_access(op_sw, 32'h8, 32'h4, $urandom());
    add_access(op_lw, 32'hc, 32'h0, '0); // Read right behind the write
    add_access(op_none, '0, '0, '0);
    add_access(op_none, '0, '0, '0);
    add_access(op_sw, ram_bytes, 32'h10, $urandom()); // Wraps onto word 4
    add_access(op_lw, 32'h10, 32'h0, '0);
    for (int lane = 0; lane < 4; lane++) begin
      add_access(op_sb, 32'h10, lane, $urandom());
      add_access(op_lw, 32'h10, 32'h0, '0);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      add_access(op_sh, 32'h14, lane, $urandom());
      add_access(op_lw, 32'h14, 32'h0, '0);
    end
    // Byte and half patterns with the sign bit both set and clear
    add_access(op_sw, 32'h18, 32'h0, 32'h8001_7ffe);
    add_access(op_sw, 32'h1c, 32'h0, 32'h7f80_ff00);
    for (int lane = 0; lane < 4; lane++) begin
      add_access(op_lb, 32'h18, lane, '0);
      add_access(op_lbu, 32'h18, lane, '0);
      add_access(op_lb, 32'h1c, lane, '0);
      add_access(op_lbu, 32'h1c, lane, '0);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      add_access(op_lh, 32'h18, lane, '0);
      add_access(op_lhu, 32'h18, lane, '0);
      add_access(op_lh, 32'h1c, lane, '0);
      add_access(op_lhu, 32'h1c, lane, '0);
    end
    add_access(op_lw, 32'h20, 32'h0, '0);
    add_access(op_sh, 32'h20, 32'h1, $urandom());
    add_access(op_sh, 32'h20, 32'h3, $urandom());
    add_access(op_sw, 32'h20, 32'h2, $urandom());
    add_access(op_sw, 32'h24, 32'h1, $urandom());
    add_access(op_lh, 32'h24, 32'h3, '0);
    add_access(op_lhu, 32'h20, 32'h1, '0);
    add_access(op_lw, 32'h28, 32'h3, '0);
    add_access(op_lw, 32'h20, 32'h0, '0);
    add_access(op_lw, 32'h24, 32'h0, '0);
    add_access(op_lw, 32'h28, 32'h0, '0);
    for (int r = 0; r < 48; r++) begin
      addr = $urandom_range(0, 63);
      off = $urandom_range(0, 31);
      base = addr - off;
      if ($urandom_range(0, 3) == 0) base = base + ram_bytes;
      add_access(mixed_ops[$urandom_range(0, 7)], base, off, $urandom());
    end
  endtask

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_result(input string what, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Results are due exactly two cycles after issue and in issue order
  always @(negedge clock) begin
    if (cycle > 0) begin
      if (result_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: result_valid_o pulsed at %0t ns with no load in flight", $time);
          stop_run();
        end else begin
          if (cycle - issue_q[0] != 2) begin
            $display("ERROR: load result arrived %0d cycles after issue", cycle - issue_q[0]);
            stop_run();
          end
          check_result("load result", mem_result_o, exp_q[0]);
          last_result = exp_q.pop_front();
          void'(issue_q.pop_front());
        end
      end else begin
        check_result("held load result", mem_result_o, last_result);
      end
    end
  end

  // The bound checker counts each failed interface assertion
  always @(negedge clock) begin
    if (dut0.assert0.failure_count != 0) begin
      $display("ERROR: an interface assertion failed before %0t ns", $time);
      stop_run();
    end
  end

  initial begin
    wait (table_built);
    repeat (rows.size() * 10 + 100) @(posedge clock);
    $display("ERROR: watchdog expired before the table finished");
    stop_run();
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    req_i = 1'b0;
    lsu_op_i = op_none;
    rdata1_i = '0;
    imm_i = '0;
    rdata2_i = '0;
    void'($urandom(32'hb0fd_4f87));
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    foreach (rows[i]) begin
      @(negedge clock);
      req_i = (rows[i].op != op_none);
      lsu_op_i = rows[i].op;
      rdata1_i = rows[i].base;
      imm_i = rows[i].offset;
      rdata2_i = rows[i].store_data;
      if (is_load_op(rows[i].op) && !rows[i].exp_misaligned) begin
        exp_q.push_back(rows[i].exp_result);
        issue_q.push_back(cycle);
      end
      #2;
      check_flag($sformatf("misaligned_o on row %0d", i), misaligned_o, rows[i].exp_misaligned);
    end
    @(negedge clock);
    req_i = 1'b0;
    lsu_op_i = op_none;
    repeat (4) @(posedge clock);
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d loads were issued but never returned a result", exp_q.size());
      stop_run();
    end else if (dut0.assert0.failure_count != 0) begin
      $display("ERROR: %0d interface assertions failed", dut0.assert0.failure_count);
      stop_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire
